// File: design/uart_settings.svh
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// Serial timing, in system clocks per bit
`define UART_CLKS_PER_BIT 10

// Transmit queue entries, also the host's starting credit count
`define UART_FIFO_DEPTH 4

// Frame layout
`define UART_DATA_BITS 8 // Data bits per frame, LSB first
`define UART_START_BIT 1'b0
`define UART_STOP_BIT 1'b1 // Also the idle line level

`endif

// File: design/uart_pkg.sv
package uart_pkg;

  // One byte queued for transmission
  typedef struct packed {
    logic [7:0] data;
  } tx_item_t;

  // One received byte with its stop-bit status
  typedef struct packed {
    logic [7:0] data;
    logic       framing_error; // Stop bit sampled low
  } rx_item_t;

  typedef enum logic [2:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP,
    TX_CLEANUP
  } tx_state_t;

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP,
    RX_CLEANUP
  } rx_state_t;

endpackage

// File: design/uart_tx_fifo.sv
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_tx_fifo
  import uart_pkg::*;
(
  input  logic     i_Clock,
  input  logic     i_rst_n,
  input  logic     i_push,
  input  tx_item_t i_push_item,
  input  logic     i_pop,
  output tx_item_t o_pop_item,
  output logic     o_not_empty,
  output logic     o_credit
);

  localparam int DEPTH = `UART_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

  tx_item_t         r_mem [DEPTH];
  logic [PTR_W-1:0] r_wr_ptr;
  logic [PTR_W-1:0] r_rd_ptr;
  logic [CNT_W-1:0] r_count;
  logic             w_pop_ok;

  // Host credits guarantee space, so a push is always taken
  assign w_pop_ok    = i_pop && o_not_empty;
  assign o_not_empty = (r_count != '0);
  assign o_pop_item  = r_mem[r_rd_ptr]; // Head of queue, shown before the pop
  assign o_credit    = w_pop_ok;         // One credit back per byte leaving

  always_ff @(posedge i_Clock)
  begin
    if (i_push)
    begin
      r_mem[r_wr_ptr] <= i_push_item;
    end
  end

  always_ff @(posedge i_Clock)
  begin
    if (!i_rst_n)
    begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_count  <= '0;
    end
    else
    begin
      if (i_push)
      begin
        r_wr_ptr <= (r_wr_ptr == LAST_PTR) ? '0 : r_wr_ptr + 1'b1;
      end

      if (w_pop_ok)
      begin
        r_rd_ptr <= (r_rd_ptr == LAST_PTR) ? '0 : r_rd_ptr + 1'b1;
      end

      // Occupancy only moves when one side acts alone
      if (i_push && !w_pop_ok)
      begin
        r_count <= r_count + 1'b1;
      end
      else if (w_pop_ok && !i_push)
      begin
        r_count <= r_count - 1'b1;
      end
    end
  end

endmodule

// File: design/uart_tx.sv
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_tx
  import uart_pkg::*;
#(
  parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
)
(
  input  logic     i_Clock,
  input  logic     i_rst_n,
  input  logic     i_tx_valid,
  input  tx_item_t i_tx_item,
  output logic     o_tx_ready,
  output logic     o_tx_serial,
  output logic     o_tx_active
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
  localparam int IDX_W = $clog2(`UART_DATA_BITS);
  localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [IDX_W-1:0] LAST_BIT = IDX_W'(`UART_DATA_BITS - 1);

  tx_state_t                  r_state;
  logic [CNT_W-1:0]           r_clk_count;
  logic [IDX_W-1:0]           r_bit_index;
  logic [`UART_DATA_BITS-1:0] r_tx_data;
  logic                       w_accept;
  logic                       w_bit_done;

  assign o_tx_ready = (r_state == TX_IDLE);
  assign w_accept   = o_tx_ready && i_tx_valid;
  assign w_bit_done = (r_clk_count == LAST_CNT);

  // Byte shifts right as each bit is put on the line
  always_ff @(posedge i_Clock)
  begin
    if (w_accept)
    begin
      r_tx_data <= i_tx_item.data;
    end
    else if (w_bit_done && (r_state == TX_START || r_state == TX_DATA))
    begin
      r_tx_data <= r_tx_data >> 1;
    end
  end

  always_ff @(posedge i_Clock)
  begin
    if (!i_rst_n)
    begin
      r_state     <= TX_IDLE;
      r_clk_count <= '0;
      r_bit_index <= '0;
      o_tx_serial <= `UART_STOP_BIT;
      o_tx_active <= 1'b0;
    end
    else
    begin
      case (r_state)
        TX_IDLE:
        begin
          r_clk_count <= '0;
          r_bit_index <= '0;
          if (i_tx_valid)
          begin
            o_tx_serial <= `UART_START_BIT; // Start bit goes out on the next edge
            o_tx_active <= 1'b1;
            r_state     <= TX_START;
          end
        end

        TX_START:
        begin
          if (w_bit_done)
          begin
            r_clk_count <= '0;
            o_tx_serial <= r_tx_data[0];
            r_state     <= TX_DATA;
          end
          else
          begin
            r_clk_count <= r_clk_count + 1'b1;
          end
        end

        TX_DATA:
        begin
          if (w_bit_done)
          begin
            r_clk_count <= '0;
            if (r_bit_index != LAST_BIT)
            begin
              r_bit_index <= r_bit_index + 1'b1;
              o_tx_serial <= r_tx_data[0];
            end
            else
            begin
              r_bit_index <= '0;
              o_tx_serial <= `UART_STOP_BIT;
              r_state     <= TX_STOP;
            end
          end
          else
          begin
            r_clk_count <= r_clk_count + 1'b1;
          end
        end

        TX_STOP:
        begin
          if (w_bit_done)
          begin
            r_clk_count <= '0;
            o_tx_active <= 1'b0;
            r_state     <= TX_CLEANUP;
          end
          else
          begin
            r_clk_count <= r_clk_count + 1'b1;
          end
        end

        TX_CLEANUP: r_state <= TX_IDLE; // Line stays high for this cycle

        default: r_state <= TX_IDLE;
      endcase
    end
  end

endmodule

// File: design/uart_rx.sv
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_rx
  import uart_pkg::*;
#(
  parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
)
(
  input  logic     i_Clock,
  input  logic     i_rst_n,
  input  logic     i_rx_serial,
  output logic     o_rx_valid,
  output rx_item_t o_rx_item
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
  localparam int IDX_W = $clog2(`UART_DATA_BITS);
  localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF_CNT = CNT_W'((CLKS_PER_BIT - 1) / 2);
  localparam logic [IDX_W-1:0] LAST_BIT = IDX_W'(`UART_DATA_BITS - 1);

  rx_state_t                  r_state;
  logic [CNT_W-1:0]           r_clk_count;
  logic [IDX_W-1:0]           r_bit_index;
  logic                       r_rx_meta;
  logic                       r_rx_sync;
  logic                       r_rx_prev;
  logic [`UART_DATA_BITS-1:0] r_rx_data;
  logic                       r_frame_err;
  logic                       w_bit_done;

  assign w_bit_done = (r_clk_count == LAST_CNT);

  assign o_rx_item.data          = r_rx_data;
  assign o_rx_item.framing_error = r_frame_err;

  // Data enters at the top, so the first bit ends up as the LSB
  always_ff @(posedge i_Clock)
  begin
    if (r_state == RX_DATA && w_bit_done)
    begin
      r_rx_data <= {r_rx_sync, r_rx_data[`UART_DATA_BITS-1:1]};
    end

    if (r_state == RX_STOP && w_bit_done)
    begin
      r_frame_err <= (r_rx_sync != `UART_STOP_BIT);
    end
  end

  always_ff @(posedge i_Clock)
  begin
    if (!i_rst_n)
    begin
      r_rx_meta   <= `UART_STOP_BIT; // Sync chain starts at idle level
      r_rx_sync   <= `UART_STOP_BIT;
      r_rx_prev   <= `UART_STOP_BIT;
      r_state     <= RX_IDLE;
      r_clk_count <= '0;
      r_bit_index <= '0;
      o_rx_valid  <= 1'b0;
    end
    else
    begin
      r_rx_meta <= i_rx_serial;
      r_rx_sync <= r_rx_meta;
      r_rx_prev <= r_rx_sync;

      case (r_state)
        RX_IDLE:
        begin
          r_clk_count <= '0;
          r_bit_index <= '0;
          if (r_rx_prev == `UART_STOP_BIT && r_rx_sync == `UART_START_BIT)
          begin
            r_state <= RX_START;
          end
        end

        // Recheck at mid-bit to reject glitches
        RX_START:
        begin
          if (r_clk_count == HALF_CNT)
          begin
            r_clk_count <= '0;
            r_state     <= (r_rx_sync == `UART_START_BIT) ? RX_DATA : RX_IDLE;
          end
          else
          begin
            r_clk_count <= r_clk_count + 1'b1;
          end
        end

        RX_DATA:
        begin
          if (w_bit_done)
          begin
            r_clk_count <= '0;
            if (r_bit_index != LAST_BIT)
            begin
              r_bit_index <= r_bit_index + 1'b1;
            end
            else
            begin
              r_bit_index <= '0;
              r_state     <= RX_STOP;
            end
          end
          else
          begin
            r_clk_count <= r_clk_count + 1'b1;
          end
        end

        RX_STOP:
        begin
          if (w_bit_done)
          begin
            r_clk_count <= '0;
            o_rx_valid  <= 1'b1; // Byte shown the cycle after the stop sample
            r_state     <= RX_CLEANUP;
          end
          else
          begin
            r_clk_count <= r_clk_count + 1'b1;
          end
        end

        RX_CLEANUP:
        begin
          o_rx_valid <= 1'b0;
          r_state    <= RX_IDLE;
        end

        default: r_state <= RX_IDLE;
      endcase
    end
  end

endmodule

// File: design/uart_top.sv
`timescale 1ns/1ps

module uart_top
  import uart_pkg::*;
(
  input  logic     i_Clock,
  input  logic     i_rst_n,
  input  logic     i_tx_valid,
  input  tx_item_t i_tx_item,
  output logic     o_tx_credit,
  output logic     o_tx_serial,
  output logic     o_tx_active,
  input  logic     i_rx_serial,
  output logic     o_rx_valid,
  output rx_item_t o_rx_item
);

  tx_item_t w_fifo_item;
  logic     w_fifo_not_empty;
  logic     w_tx_ready;
  logic     w_fifo_pop;

  // Byte moves when the queue has one and the serializer is idle
  assign w_fifo_pop = w_tx_ready && w_fifo_not_empty;

  uart_tx_fifo u_tx_fifo (
    .i_Clock     (i_Clock),
    .i_rst_n     (i_rst_n),
    .i_push      (i_tx_valid),
    .i_push_item (i_tx_item),
    .i_pop       (w_fifo_pop),
    .o_pop_item  (w_fifo_item),
    .o_not_empty (w_fifo_not_empty),
    .o_credit    (o_tx_credit)
  );

  uart_tx u_tx (
    .i_Clock     (i_Clock),
    .i_rst_n     (i_rst_n),
    .i_tx_valid  (w_fifo_not_empty),
    .i_tx_item   (w_fifo_item),
    .o_tx_ready  (w_tx_ready),
    .o_tx_serial (o_tx_serial),
    .o_tx_active (o_tx_active)
  );

  uart_rx u_rx (
    .i_Clock     (i_Clock),
    .i_rst_n     (i_rst_n),
    .i_rx_serial (i_rx_serial),
    .o_rx_valid  (o_rx_valid),
    .o_rx_item   (o_rx_item)
  );

endmodule

// File: bench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen
#(
  parameter real PERIOD_NS = 10.0
)
(
  output logic o_clock
);

  initial
  begin
    o_clock = 1'b0;
    forever #(PERIOD_NS / 2.0) o_clock = ~o_clock;
  end

endmodule

// File: bench/tb_uart_top.sv
`timescale 1ns/1ps
`include "uart_settings.svh"

module tb_uart_top
  import uart_pkg::*;
();

  localparam int CLKS     = `UART_CLKS_PER_BIT;
  localparam int DEPTH    = `UART_FIFO_DEPTH;
  localparam int NUM_LOOP = 200;
  localparam int NUM_DRV  = 24;
  // Loopback frames back to back, driven frames with idle, plus margin
  localparam int LIMIT = NUM_LOOP * (10 * CLKS + 2) + NUM_DRV * (12 * CLKS) + 2000;

  logic     clk;
  logic     rst_n;
  logic     tx_valid;
  tx_item_t tx_item;
  logic     tx_credit;
  logic     tx_serial;
  logic     tx_active;
  logic     rx_serial;
  logic     rx_valid;
  rx_item_t rx_item;
  logic     use_driver; // Frame driver feeds the receiver instead of the line
  logic     drv_serial;

  integer   seed;
  int       errors;
  int       cycles;
  int       credits;
  int       credit_pulses;
  int       pushed;
  int       rx_count;
  rx_item_t rx_expect[$];
  logic [7:0] line_expect[$];

  tb_clock_gen u_clock (.o_clock(clk));

  assign rx_serial = use_driver ? drv_serial : tx_serial;

  uart_top i_dut (
    .i_Clock     (clk),
    .i_rst_n     (rst_n),
    .i_tx_valid  (tx_valid),
    .i_tx_item   (tx_item),
    .o_tx_credit (tx_credit),
    .o_tx_serial (tx_serial),
    .o_tx_active (tx_active),
    .i_rx_serial (rx_serial),
    .o_rx_valid  (rx_valid),
    .o_rx_item   (rx_item)
  );

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("FAIL time=%0t %s expected=%0h actual=%0h", $time, name, expected, actual);
    errors++;
  endtask

  task automatic report_error(input string msg);
    $display("ERROR time=%0t %s", $time, msg);
    errors++;
  endtask

  // One clock to the next falling edge counting returned credits
  task automatic tick();
    @(negedge clk);
    if (rst_n && tx_credit)
    begin
      credits++;
      credit_pulses++;
      if (credits > DEPTH)
        report_error("host credit count went above the FIFO depth");
    end
  endtask

  task automatic drive_bit(input logic level);
    tick();
    drv_serial = level;
    repeat (CLKS - 1) tick();
  endtask

  task automatic drive_frame(input logic [7:0] data, input logic bad_stop);
    int i;
    drive_bit(1'b0);
    for (i = 0; i < 8; i++)
      drive_bit(data[i]); // LSB first
    drive_bit(!bad_stop);
    if (bad_stop)
      drive_bit(1'b1); // Idle high so the next start edge is seen
  endtask

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= LIMIT)
    begin
      $display("ERROR time=%0t run timed out after %0d cycles", $time, cycles);
      $display("Verification failed");
      $finish;
    end
  end

  // Receiver output against the expected queue
  always @(negedge clk)
  begin
    if (rst_n && rx_valid)
    begin
      rx_count++;
      if (rx_expect.size() == 0)
        report_error("receiver presented a byte that was never sent");
      else if (rx_item !== rx_expect[0])
      begin
        report_mismatch("o_rx_item", 32'(rx_expect[0]), 32'(rx_item));
        void'(rx_expect.pop_front());
      end
      else
        void'(rx_expect.pop_front());
    end
  end

  // Line decoder sampling o_tx_serial at bit centres
  initial
  begin : line_decoder
    logic       prev;
    logic [7:0] bits;
    logic [7:0] expect_byte;
    int         i;
    prev = 1'b1;
    forever
    begin
      @(negedge clk);
      if (rst_n && prev && !tx_serial)
      begin
        repeat (CLKS / 2) @(negedge clk);
        if (tx_serial !== 1'b0) report_mismatch("o_tx_serial start", 0, 32'(tx_serial));
        if (tx_active !== 1'b1) report_mismatch("o_tx_active", 1, 32'(tx_active));
        for (i = 0; i < 8; i++)
        begin
          repeat (CLKS) @(negedge clk);
          bits[i] = tx_serial;
          if (tx_active !== 1'b1) report_mismatch("o_tx_active", 1, 32'(tx_active));
        end
        repeat (CLKS) @(negedge clk);
        if (tx_serial !== 1'b1) report_mismatch("o_tx_serial stop", 1, 32'(tx_serial));
        if (tx_active !== 1'b1) report_mismatch("o_tx_active", 1, 32'(tx_active));
        if (line_expect.size() == 0)
          report_error("frame seen on o_tx_serial with no byte queued");
        else
        begin
          expect_byte = line_expect.pop_front();
          if (bits !== expect_byte)
            report_mismatch("o_tx_serial data", 32'(expect_byte), 32'(bits));
        end
      end
      prev = tx_serial;
    end
  end

  initial
  begin : stimulus
    logic [7:0] data;
    logic       bad;
    int         r;
    int         i;
    seed = 77;
    errors = 0;
    cycles = 0;
    credit_pulses = 0;
    pushed = 0;
    rx_count = 0;
    credits = DEPTH;
    rst_n = 1'b0;
    tx_valid = 1'b0;
    tx_item = '0;
    use_driver = 1'b0;
    drv_serial = 1'b1;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    tick();

    if (tx_serial !== 1'b1) report_mismatch("o_tx_serial", 1, 32'(tx_serial));
    if (tx_active !== 1'b0) report_mismatch("o_tx_active", 0, 32'(tx_active));
    if (tx_credit !== 1'b0) report_mismatch("o_tx_credit", 0, 32'(tx_credit));
    if (rx_valid !== 1'b0) report_mismatch("o_rx_valid", 0, 32'(rx_valid));

    // Loopback with random gaps while credits remain
    while (pushed < NUM_LOOP)
    begin
      tick();
      r = $random(seed);
      if (credits > 0 && r[1:0] != 2'b00)
      begin
        r = $random(seed);
        data = r[7:0];
        tx_item.data = data;
        tx_valid = 1'b1;
        credits--;
        pushed++;
        rx_expect.push_back({data, 1'b0});
        line_expect.push_back(data);
      end
      else
        tx_valid = 1'b0;
    end
    tick();
    tx_valid = 1'b0;
    while (rx_count < NUM_LOOP)
      tick();
    repeat (4) tick();

    if (credit_pulses != pushed) report_mismatch("o_tx_credit pulses", pushed, credit_pulses);
    if (credits != DEPTH) report_mismatch("host credits", DEPTH, credits);
    if (line_expect.size() != 0) report_error("bytes pushed never appeared on o_tx_serial");

    // Frame driver with some stop bits forced low
    use_driver = 1'b1;
    for (i = 0; i < NUM_DRV; i++)
    begin
      r = $random(seed);
      data = r[7:0];
      r = $random(seed);
      bad = (r[1:0] == 2'b00) || (i == 1);
      rx_expect.push_back({data, bad});
      drive_frame(data, bad);
    end
    while (rx_count < NUM_LOOP + NUM_DRV)
      tick();
    repeat (2 * CLKS) tick();
    if (rx_expect.size() != 0) report_error("expected bytes were never received");

    $display("Errors: %0d  bytes received: %0d  credit pulses: %0d  cycles: %0d",
             errors, rx_count, credit_pulses, cycles);
    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+design
design/uart_pkg.sv
design/uart_tx_fifo.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_top.sv
bench/tb_clock_gen.sv
bench/tb_uart_top.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary -j 0 -Wno-fatal
TOP       = tb_uart_top
FILELIST  = vlog.f
BUILD_DIR = obj_dir
LOG       = sim.log

SOURCES = $(wildcard design/*.sv design/*.svh bench/*.sv)
SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
